// ==== ls_unit.f ====
+incdir+sim
source/lsu_pkg.sv
source/ls_decode.sv
source/ls_queue.sv
source/ls_mem_ctrl.sv
source/ls_result.sv
source/ls_unit.sv
sim/ls_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ls_unit_tb
FILELIST  ?= ls_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(wildcard source/*.sv sim/*.sv sim/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/ls_model.svh ====
`ifndef LS_MODEL_SVH
`define LS_MODEL_SVH

// one issued operation as the scoreboard remembers it
typedef struct packed {
    logic [31:0] addr;
    funct3_e     funct3;
    logic [31:0] data;
    logic [4:0]  rob_idx;
    logic [5:0]  pd;
} op_rec_t;

localparam int MEM_WORDS = 16;

logic [31:0] model_mem [MEM_WORDS];
op_rec_t     store_q [$];
op_rec_t     load_q [$];

function automatic logic [31:0] fill_word(int idx);
    return (idx * 32'h9e3779b1) ^ 32'h5a5a_0000 ^ idx;
endfunction

// bytes from the offset up to the access size
function automatic logic [3:0] byte_mask(funct3_e f, logic [1:0] off);
    int         size;
    logic [3:0] m;
    case (f)
        f3_b, f3_bu: size = 1;
        f3_h, f3_hu: size = 2;
        default:     size = 4;
    endcase
    for (int i = 0; i < 4; i++) begin
        m[i] = (i >= int'(off)) && (i < int'(off) + size);
    end
    return m;
endfunction

function automatic logic [31:0] lane_bits(logic [3:0] m);
    logic [31:0] b;
    for (int i = 0; i < 4; i++) begin
        b[i*8 +: 8] = {8{m[i]}};
    end
    return b;
endfunction

// store bytes as they land in the addressed lanes
function automatic logic [31:0] place_lanes(logic [31:0] data, logic [1:0] off,
                                            logic [3:0] m);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 4; i++) begin
        if (m[i]) begin
            w[i*8 +: 8] = data[(i - int'(off))*8 +: 8];
        end
    end
    return w;
endfunction

// load value after lane select and sign or zero fill
function automatic logic [31:0] extend(logic [31:0] word, logic [1:0] off, funct3_e f);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[int'(off)*8 +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (f)
        f3_b:    return 32'($signed(b));
        f3_bu:   return 32'(b);
        f3_h:    return 32'($signed(h));
        f3_hu:   return 32'(h);
        default: return word;
    endcase
endfunction

task automatic write_word(logic [31:0] addr, logic [3:0] wmask, logic [31:0] wdata);
    for (int i = 0; i < 4; i++) begin
        if (wmask[i]) begin
            model_mem[addr[5:2]][i*8 +: 8] = wdata[i*8 +: 8];
        end
    end
endtask

`endif

// ==== sim/ls_unit_tb.sv ====
`timescale 1ns/1ps

module ls_unit_tb;
    import lsu_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int N_OPS       = 400;
    localparam int CYCLE_LIMIT = N_OPS * 400;

    `include "ls_model.svh"

    logic        clk;
    logic        rst;
    logic        flush;
    logic        resp;
    logic        ready;
    logic [4:0]  rob_head;
    logic [31:0] rdata;
    ls_issue_t   issue;
    mem_req_t    req;
    load_done_t  load_done;
    store_done_t store_done;

    int errors = 0;
    int loads_checked = 0;
    int stores_checked = 0;
    int cycles = 0;
    int ready_low = 0;
    int issued = 0;
    int rst_count = 8;
    int resp_wait = 0;
    int head_delay = 0;
    int burst_left = 0;
    int store_fill = 0;
    int load_fill = 0;
    logic resp_busy = 1'b0;
    logic req_seen = 1'b0;
    logic [4:0] next_rob = '0;
    logic [4:0] head_target = '0;
    mem_op_e burst_op = op_load;

    ls_unit #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .issue      (issue),
        .ready      (ready),
        .rob_head   (rob_head),
        .req        (req),
        .rdata      (rdata),
        .resp       (resp),
        .load_done  (load_done),
        .store_done (store_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_load(input load_done_t got, input load_done_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: load_done got %h expected %h", got, exp);
        end
    endtask

    task automatic check_store(input store_done_t got, input store_done_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: store_done got %h expected %h", got, exp);
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: req got %h expected %h", got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error: ready got %h expected %h", got, exp);
        end
    endtask

    task automatic fail(input string what);
        errors++;
        $display("%s at cycle %0d", what, cycles);
    endtask

    // legal aligned address split into a random base and offset
    task automatic drive_issue(input mem_op_e op);
        funct3_e     f;
        int          sel;
        int          bo;
        logic [31:0] addr;
        logic [31:0] off;
        sel = $urandom_range(0, (op == op_load) ? 4 : 2);
        case (sel)
            0: f = f3_b;
            1: f = f3_h;
            2: f = f3_w;
            3: f = f3_bu;
            default: f = f3_hu;
        endcase
        if (f == f3_b || f == f3_bu) begin
            bo = $urandom_range(0, 3);
        end else if (f == f3_h || f == f3_hu) begin
            bo = 2 * $urandom_range(0, 1);
        end else begin
            bo = 0;
        end
        addr = 32'($urandom_range(0, MEM_WORDS - 1) * 4 + bo);
        off = 32'($urandom_range(0, 63)) - 32'd32;
        issue.valid      = 1'b1;
        issue.op         = op;
        issue.funct3     = f;
        issue.base       = addr - off;
        issue.offset     = off;
        issue.store_data = $urandom;
        issue.rob_idx    = next_rob;
        issue.pd         = 6'($urandom_range(0, 63));
        next_rob++;
        issued++;
    endtask

    // memory responder, rob head and issue stimulus
    always @(negedge clk) begin
        if (rst_count > 0) begin
            rst_count--;
            if (rst_count == 0) begin
                rst = 1'b0;
            end
        end else begin
            resp = 1'b0;
            // a request counts once the DUT has taken it at a rising edge
            if (!resp_busy && req_seen) begin
                resp_busy = 1'b1;
                resp_wait = $urandom_range(1, 4);
            end
            if (resp_busy) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    resp = 1'b1;
                    rdata = model_mem[req.addr[5:2]];
                    resp_busy = 1'b0;
                end
            end
            if (store_q.size() != 0) begin
                if (store_q[0].rob_idx != head_target) begin
                    head_target = store_q[0].rob_idx;
                    head_delay = $urandom_range(0, 5);
                end
                if (head_delay > 0) begin
                    head_delay--;
                    rob_head = head_target ^ 5'h10;
                end else begin
                    rob_head = head_target;
                end
            end
            flush = 1'b0;
            issue = '0;
            if (burst_left == 0) begin
                burst_op = ($urandom_range(0, 1) == 0) ? op_load : op_store;
                burst_left = ($urandom_range(0, 3) == 0) ? QUEUE_DEPTH + 2 : 1;
            end
            if ($urandom_range(0, 59) == 0) begin
                flush = 1'b1;
            end else if (ready && issued < N_OPS && $urandom_range(0, 3) != 0) begin
                drive_issue(burst_op);
                burst_left--;
            end
        end
    end

    always @(posedge clk) begin
        op_rec_t     rec;
        load_done_t  exp_ld;
        store_done_t exp_st;
        mem_req_t    exp_rq;
        mem_req_t    got_rq;
        logic        exp_ready;
        if (!rst) begin
            cycles++;
            if (!ready) begin
                ready_low++;
            end
            // queue room as counted from pushes and first requests
            exp_ready = (store_fill < QUEUE_DEPTH) && (load_fill < QUEUE_DEPTH);
            check_ready(ready, exp_ready);
            if (store_done.valid) begin
                if (store_q.size() == 0) begin
                    fail("store_done pulsed with no store outstanding");
                end else begin
                    rec = store_q.pop_front();
                    exp_st.valid   = 1'b1;
                    exp_st.rob_idx = rec.rob_idx;
                    check_store(store_done, exp_st);
                    stores_checked++;
                end
            end
            if (load_done.valid) begin
                if (load_q.size() == 0) begin
                    fail("load_done pulsed with no load outstanding");
                end else begin
                    rec = load_q.pop_front();
                    exp_ld.valid   = 1'b1;
                    exp_ld.rob_idx = rec.rob_idx;
                    exp_ld.pd      = rec.pd;
                    exp_ld.data    = extend(model_mem[rec.addr[5:2]], rec.addr[1:0],
                                            rec.funct3);
                    check_load(load_done, exp_ld);
                    loads_checked++;
                end
            end
            // new request, checked once when it first shows up
            if ((req.rmask | req.wmask) != 0 && !req_seen) begin
                req_seen = 1'b1;
                if (req.wmask != 0) begin
                    store_fill--;
                end else begin
                    load_fill--;
                end
                got_rq = req;
                got_rq.wdata = req.wdata & lane_bits(req.wmask);
                if (req.wmask != 0) begin
                    if (store_q.size() == 0) begin
                        fail("store request with no store outstanding");
                    end else begin
                        rec = store_q[0];
                        if (rob_head != rec.rob_idx) begin
                            fail("store request sent before rob_head reached it");
                        end
                        exp_rq.addr  = {rec.addr[31:2], 2'b00};
                        exp_rq.rmask = '0;
                        exp_rq.wmask = byte_mask(rec.funct3, rec.addr[1:0]);
                        exp_rq.wdata = place_lanes(rec.data, rec.addr[1:0], exp_rq.wmask);
                        check_req(got_rq, exp_rq);
                    end
                end else if (store_q.size() != 0) begin
                    fail("load request sent while a store is outstanding");
                end else if (load_q.size() == 0) begin
                    fail("load request with no load outstanding");
                end else begin
                    rec = load_q[0];
                    exp_rq.addr  = {rec.addr[31:2], 2'b00};
                    exp_rq.rmask = byte_mask(rec.funct3, rec.addr[1:0]);
                    exp_rq.wmask = '0;
                    exp_rq.wdata = '0;
                    check_req(got_rq, exp_rq);
                end
            end
            if (resp) begin
                req_seen = 1'b0;
                write_word(req.addr, req.wmask, req.wdata);
            end
            if (issue.valid && ready) begin
                rec.addr    = issue.base + issue.offset;
                rec.funct3  = issue.funct3;
                rec.data    = issue.store_data;
                rec.rob_idx = issue.rob_idx;
                rec.pd      = issue.pd;
                if (issue.op == op_store) begin
                    store_q.push_back(rec);
                    store_fill++;
                end else begin
                    load_q.push_back(rec);
                    load_fill++;
                end
            end
            // everything issued so far is dropped
            if (flush) begin
                store_q.delete();
                load_q.delete();
                store_fill = 0;
                load_fill = 0;
            end
        end
    end

    // run limit in clock cycles after reset
    initial begin
        wait (cycles > CYCLE_LIMIT);
        $display("Timeout: operations still pending after %0d cycles", cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'h8f81));
        rst = 1'b1;
        flush = 1'b0;
        resp = 1'b0;
        rdata = '0;
        issue = '0;
        rob_head = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = fill_word(i);
        end
        while (issued < N_OPS) begin
            @(posedge clk);
        end
        while (store_q.size() != 0 || load_q.size() != 0 || resp_busy || req_seen) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (ready_low == 0) begin
            fail("ready never went low during the issue bursts");
        end
        $display("%0d errors, %0d loads and %0d stores checked",
                 errors, loads_checked, stores_checked);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== source/ls_unit.sv ====
`timescale 1ns/1ps

module ls_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  lsu_pkg::ls_issue_t                  issue,
    output logic                                ready,
    input  logic [lsu_pkg::ROB_IDX_BITS-1:0]    rob_head,
    output lsu_pkg::mem_req_t                   req,
    input  logic [lsu_pkg::XLEN-1:0]            rdata,
    input  logic                                resp,
    output lsu_pkg::load_done_t                 load_done,
    output lsu_pkg::store_done_t                store_done
);
    import lsu_pkg::*;

    mem_entry_t entry;
    mem_entry_t store_head;
    mem_entry_t load_head;
    mem_entry_t cur;
    logic       store_push;
    logic       load_push;
    logic       store_pop;
    logic       load_pop;
    logic       store_valid;
    logic       load_valid;
    logic       store_full;
    logic       load_full;
    logic       store_empty;
    logic       load_resp;
    logic       store_resp;

    ls_decode i_decode (
        .issue      (issue),
        .store_full (store_full),
        .load_full  (load_full),
        .ready      (ready),
        .entry      (entry),
        .store_push (store_push),
        .load_push  (load_push)
    );

    ls_queue #(.DEPTH(QUEUE_DEPTH)) i_store_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (store_push),
        .pop        (store_pop),
        .wr_entry   (entry),
        .head       (store_head),
        .head_valid (store_valid),
        .full       (store_full),
        .empty      (store_empty)
    );

    // load queue emptiness is already given by head_valid
    ls_queue #(.DEPTH(QUEUE_DEPTH)) i_load_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (load_push),
        .pop        (load_pop),
        .wr_entry   (entry),
        .head       (load_head),
        .head_valid (load_valid),
        .full       (load_full),
        .empty      ()
    );

    ls_mem_ctrl i_mem_ctrl (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .store_head  (store_head),
        .load_head   (load_head),
        .store_valid (store_valid),
        .load_valid  (load_valid),
        .store_empty (store_empty),
        .rob_head    (rob_head),
        .resp        (resp),
        .req         (req),
        .store_pop   (store_pop),
        .load_pop    (load_pop),
        .cur         (cur),
        .load_resp   (load_resp),
        .store_resp  (store_resp)
    );

    ls_result i_result (
        .clk        (clk),
        .rst        (rst),
        .cur        (cur),
        .load_resp  (load_resp),
        .store_resp (store_resp),
        .rdata      (rdata),
        .load_done  (load_done),
        .store_done (store_done)
    );

endmodule

// ==== source/ls_result.sv ====
`timescale 1ns/1ps

module ls_result (
    input  logic                         clk,
    input  logic                         rst,
    input  lsu_pkg::mem_entry_t          cur,
    input  logic                         load_resp,
    input  logic                         store_resp,
    input  logic [lsu_pkg::XLEN-1:0]     rdata,
    output lsu_pkg::load_done_t          load_done,
    output lsu_pkg::store_done_t         store_done
);
    import lsu_pkg::*;

    logic [XLEN-1:0] lane;
    logic [XLEN-1:0] ext_data;

    // bring the addressed byte or halfword down to bit 0
    assign lane = rdata >> {cur.addr[1:0], 3'b000};

    always_comb begin
        unique case (cur.funct3)
            f3_b:    ext_data = {{24{lane[7]}}, lane[7:0]};
            f3_bu:   ext_data = {24'b0, lane[7:0]};
            f3_h:    ext_data = {{16{lane[15]}}, lane[15:0]};
            f3_hu:   ext_data = {16'b0, lane[15:0]};
            default: ext_data = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_resp) begin
            load_done.rob_idx <= cur.rob_idx;
            load_done.pd      <= cur.pd;
            load_done.data    <= ext_data;
        end
        if (rst) begin
            load_done.valid <= 1'b0;
        end else begin
            load_done.valid <= load_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (store_resp) begin
            store_done.rob_idx <= cur.rob_idx;
        end
        if (rst) begin
            store_done.valid <= 1'b0;
        end else begin
            store_done.valid <= store_resp;
        end
    end

endmodule

// ==== source/ls_mem_ctrl.sv ====
`timescale 1ns/1ps

module ls_mem_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  lsu_pkg::mem_entry_t                 store_head,
    input  lsu_pkg::mem_entry_t                 load_head,
    input  logic                                store_valid,
    input  logic                                load_valid,
    input  logic                                store_empty,
    input  logic [lsu_pkg::ROB_IDX_BITS-1:0]    rob_head,
    input  logic                                resp,
    output lsu_pkg::mem_req_t                   req,
    output logic                                store_pop,
    output logic                                load_pop,
    output lsu_pkg::mem_entry_t                 cur,
    output logic                                load_resp,
    output logic                                store_resp
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_load,
        wait_store,
        squash
    } state_e;

    state_e state;
    state_e state_next;

    logic store_go;
    logic load_go;

    function automatic mem_req_t to_req(mem_entry_t e);
        mem_req_t r;
        r.addr  = {e.addr[XLEN-1:2], 2'b00};
        r.rmask = (e.op == op_load) ? e.mask : '0;
        r.wmask = (e.op == op_store) ? e.mask : '0;
        r.wdata = e.wdata;
        return r;
    endfunction

    // a store waits for the rob head, a load for an empty store queue
    assign store_go = (state == idle) && !flush && store_valid &&
                      (store_head.rob_idx == rob_head);
    assign load_go  = (state == idle) && !flush && load_valid && store_empty;

    assign store_pop = store_go;
    assign load_pop  = load_go;

    // held from cur while a request is outstanding, squash included
    always_comb begin
        if (store_go) begin
            req = to_req(store_head);
        end else if (load_go) begin
            req = to_req(load_head);
        end else if (state != idle) begin
            req = to_req(cur);
        end else begin
            req = '0;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            idle: begin
                if (store_go) begin
                    state_next = wait_store;
                end else if (load_go) begin
                    state_next = wait_load;
                end
            end
            wait_load, wait_store: begin
                if (resp) begin
                    state_next = idle;
                end else if (flush) begin
                    state_next = squash;
                end
            end
            squash: begin
                if (resp) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_go) begin
            cur <= store_head;
        end else if (load_go) begin
            cur <= load_head;
        end
    end

    // no completion for anything flushed
    assign load_resp  = (state == wait_load) && resp && !flush;
    assign store_resp = (state == wait_store) && resp && !flush;

endmodule

// ==== source/ls_queue.sv ====
`timescale 1ns/1ps

module ls_queue #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                push,
    input  logic                pop,
    input  lsu_pkg::mem_entry_t wr_entry,
    output lsu_pkg::mem_entry_t head,
    output logic                head_valid,
    output logic                full,
    output logic                empty
);
    import lsu_pkg::*;

    localparam int PTR_BITS = $clog2(DEPTH);

    mem_entry_t slots [DEPTH];

    // extra msb tells full from empty
    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                   (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    assign head_valid = !empty;
    assign head       = slots[rd_ptr[PTR_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr[PTR_BITS-1:0]] <= wr_entry;
        end
    end

endmodule

// ==== source/ls_decode.sv ====
`timescale 1ns/1ps

module ls_decode (
    input  lsu_pkg::ls_issue_t  issue,
    input  logic                store_full,
    input  logic                load_full,
    output logic                ready,
    output lsu_pkg::mem_entry_t entry,
    output logic                store_push,
    output logic                load_push
);
    import lsu_pkg::*;

    logic [XLEN-1:0]   addr;
    logic [XLEN/8-1:0] mask;
    logic [XLEN-1:0]   lane_data;
    logic              accept;

    assign addr = issue.base + issue.offset;

    // byte enables follow the low address bits
    always_comb begin
        unique case (issue.funct3)
            f3_b, f3_bu: begin
                mask = 4'b0001 << addr[1:0];
            end
            f3_h, f3_hu: begin
                mask = 4'b0011 << addr[1:0];
            end
            f3_w: begin
                mask = 4'b1111;
            end
            default: begin
                mask = '0;
            end
        endcase
    end

    // move store bytes into their lanes
    always_comb begin
        if (issue.op == op_store) begin
            lane_data = issue.store_data << {addr[1:0], 3'b000};
        end else begin
            lane_data = '0;
        end
    end

    always_comb begin
        entry.op      = issue.op;
        entry.funct3  = issue.funct3;
        entry.addr    = addr;
        entry.mask    = mask;
        entry.wdata   = lane_data;
        entry.rob_idx = issue.rob_idx;
        entry.pd      = issue.pd;
    end

    // stall issue if either queue is out of room
    assign ready = !store_full && !load_full;

    assign accept     = issue.valid && ready;
    assign store_push = accept && (issue.op == op_store);
    assign load_push  = accept && (issue.op == op_load);

endmodule

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

    localparam int XLEN         = 32;
    localparam int ROB_IDX_BITS = 5;
    localparam int PREG_BITS    = 6;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // rv32i funct3 widths, stores reuse b, h and w
    typedef enum logic [2:0] {
        f3_b  = 3'b000,
        f3_h  = 3'b001,
        f3_w  = 3'b010,
        f3_bu = 3'b100,
        f3_hu = 3'b101
    } funct3_e;

    // operation as it leaves the register file read
    typedef struct packed {
        logic                    valid;
        mem_op_e                 op;
        funct3_e                 funct3;
        logic [XLEN-1:0]         base;
        logic [XLEN-1:0]         offset;
        logic [XLEN-1:0]         store_data;
        logic [ROB_IDX_BITS-1:0] rob_idx;
        logic [PREG_BITS-1:0]    pd;
    } ls_issue_t;

    // decoded queue entry
    typedef struct packed {
        mem_op_e                 op;
        funct3_e                 funct3;
        logic [XLEN-1:0]         addr;
        logic [XLEN/8-1:0]       mask;
        logic [XLEN-1:0]         wdata;
        logic [ROB_IDX_BITS-1:0] rob_idx;
        logic [PREG_BITS-1:0]    pd;
    } mem_entry_t;

    // data memory port, addr is word aligned
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [XLEN/8-1:0] rmask;
        logic [XLEN/8-1:0] wmask;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    valid;
        logic [ROB_IDX_BITS-1:0] rob_idx;
        logic [PREG_BITS-1:0]    pd;
        logic [XLEN-1:0]         data;
    } load_done_t;

    typedef struct packed {
        logic                    valid;
        logic [ROB_IDX_BITS-1:0] rob_idx;
    } store_done_t;

endpackage
